// ==== source/address_decoder.sv ====
`timescale 1ns/1ps

module address_decoder
    import f2_pkg::*;
(
    input  logic                cpu_as_n,
    input  logic [2:0]          cpu_fc,
    input  logic [CPU_AW-1:0]   cpu_addr,
    input  logic [REGION_W-1:0] work_base,
    input  logic [REGION_W-1:0] io_base,

    output logic                work_cs,
    output logic                io_cs,
    output logic                iack
);

    // Function code of an interrupt acknowledge cycle
    localparam logic [2:0] FC_IACK = 3'b111;

    logic                strobe;
    logic [REGION_W-1:0] region;
    logic                work_hit;
    logic                io_hit;

    //////////////////////////////////////////////////////////////////////
    // Cycle type

    assign strobe = ~cpu_as_n;
    assign iack   = strobe & (cpu_fc == FC_IACK);

    // Upper byte-address bits pick a 64 KB region
    assign region = cpu_addr[CPU_AW-1 -: REGION_W];

    assign work_hit = (region == work_base);
    assign io_hit   = (region == io_base);

    //////////////////////////////////////////////////////////////////////
    // Chip selects

    always_comb begin
        work_cs = 1'b0;
        io_cs   = 1'b0;
        if (strobe && !iack) begin
            if (work_hit) begin
                work_cs = 1'b1;
            end else if (io_hit) begin   // Work RAM wins on overlap
                io_cs = 1'b1;
            end
        end
    end

endmodule

// ==== source/board_config.sv ====
`timescale 1ns/1ps

module board_config
    import f2_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic [GAME_W-1:0]   game,

    output logic [REGION_W-1:0] work_base,
    output logic [REGION_W-1:0] io_base,
    output logic                io_swap
);

    logic [GAME_W-1:0]   game_q;     // Game id captured while in reset
    logic [REGION_W-1:0] sel_work;
    logic [REGION_W-1:0] sel_io;
    logic                sel_swap;

    //////////////////////////////////////////////////////////////////////
    // Memory map table

    always_comb begin
        case (game_q)
            GAME_DINOREX: begin
                sel_work = 8'h60;
                sel_io   = 8'h40;
                sel_swap = 1'b0;
            end
            GAME_QJINSEI: begin
                sel_work = 8'h30;
                sel_io   = 8'hb0;
                sel_swap = 1'b1;   // TE7750 style byte order
            end
            default: begin     // Finalb and unknown ids
                sel_work = 8'h10;
                sel_io   = 8'h30;
                sel_swap = 1'b0;
            end
        endcase
    end

    // Map stays at the default until the first cycle out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            game_q    <= game;
            work_base <= 8'h10;
            io_base   <= 8'h30;
            io_swap   <= 1'b0;
        end else begin
            work_base <= sel_work;
            io_base   <= sel_io;
            io_swap   <= sel_swap;
        end
    end

endmodule

// ==== source/f2_cpu_bus.sv ====
`timescale 1ns/1ps

module f2_cpu_bus
    import f2_pkg::*;
#(
    parameter int WORK_RAM_AW = 15
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [GAME_W-1:0] game,

    input  logic              cpu_as_n,
    input  logic [1:0]        cpu_ds_n,
    input  logic              cpu_rw,
    input  logic [2:0]        cpu_fc,
    input  logic [CPU_AW-1:0] cpu_addr,
    input  logic [DATA_W-1:0] cpu_dout,
    output logic [DATA_W-1:0] cpu_din,
    output logic              cpu_dtack_n,
    output logic              cpu_vpa_n,

    input  logic [7:0]        dswa,
    input  logic [7:0]        dswb,
    input  logic [9:0]        joystick_p1,
    input  logic [9:0]        joystick_p2,
    input  logic [1:0]        start,
    input  logic [1:0]        coin,

    input  logic              vblank_n,
    input  logic              dma_done,
    output logic [2:0]        ipl_n
);

    logic [REGION_W-1:0] work_base;
    logic [REGION_W-1:0] io_base;
    logic                io_swap;
    logic                work_cs;
    logic                io_cs;
    logic                iack;
    logic                as_seen;   // Strobe was low at the previous edge
    cpu_word_t           ram_q;
    cpu_word_t           rd_word;
    logic [7:0]          io_q;

    //////////////////////////////////////////////////////////////////////
    // Map and chip selects

    board_config board_config (
        .clk, .reset, .game,
        .work_base, .io_base, .io_swap
    );

    address_decoder address_decoder (
        .cpu_as_n, .cpu_fc, .cpu_addr,
        .work_base, .io_base,
        .work_cs, .io_cs, .iack
    );

    //////////////////////////////////////////////////////////////////////
    // Devices

    work_ram #(.WORK_RAM_AW(WORK_RAM_AW)) work_ram (
        .clk,
        .cs(work_cs & as_seen),   // Write lands with the acknowledge
        .cpu_rw,
        .cpu_ds_n,
        .addr(cpu_addr[WORK_RAM_AW-1:0]),
        .din(cpu_dout),
        .q(ram_q)
    );

    input_ports input_ports (
        .clk, .cs(io_cs), .io_swap,
        .index(cpu_addr[IO_IDX_W-1:0]),
        .dswa, .dswb, .joystick_p1, .joystick_p2, .start, .coin,
        .q(io_q)
    );

    interrupt_ctrl interrupt_ctrl (
        .clk, .reset, .vblank_n, .dma_done, .iack,
        .ack_level(cpu_addr[2:0]),
        .cpu_lds_n(cpu_ds_n[LANE_LOWER]),
        .ipl_n
    );

    //////////////////////////////////////////////////////////////////////
    // Read data and acknowledge

    always_comb begin
        rd_word.word = '0;   // Unmapped reads return zero
        if (work_cs) begin
            rd_word = ram_q;
        end else if (io_cs) begin
            rd_word.lanes[LANE_UPPER] = io_q;
            rd_word.lanes[LANE_LOWER] = io_q;
        end
    end

    assign cpu_din = rd_word.word;

    always_ff @(posedge clk) begin
        if (reset) begin
            as_seen     <= 1'b0;
            cpu_dtack_n <= 1'b1;
            cpu_vpa_n   <= 1'b1;
        end else begin
            as_seen     <= ~cpu_as_n;
            cpu_dtack_n <= ~(as_seen & ~cpu_as_n & ~iack);
            cpu_vpa_n   <= ~(as_seen & iack);   // Autovector
        end
    end

endmodule

// ==== source/f2_pkg.sv ====
package f2_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus widths

    localparam int CPU_AW   = 23;   // 68000 word address
    localparam int DATA_W   = 16;
    localparam int GAME_W   = 4;
    localparam int REGION_W = 8;    // Matched against byte address 23:16
    localparam int IO_IDX_W = 4;

    //////////////////////////////////////////////////////////////////////
    // Game ids

    localparam logic [GAME_W-1:0] GAME_FINALB  = 4'd0;
    localparam logic [GAME_W-1:0] GAME_DINOREX = 4'd1;
    localparam logic [GAME_W-1:0] GAME_QJINSEI = 4'd2;

    //////////////////////////////////////////////////////////////////////
    // Input-port register indices

    localparam logic [IO_IDX_W-1:0] IO_DSWA   = 4'd0;
    localparam logic [IO_IDX_W-1:0] IO_DSWB   = 4'd1;
    localparam logic [IO_IDX_W-1:0] IO_P1     = 4'd2;
    localparam logic [IO_IDX_W-1:0] IO_P2     = 4'd3;
    localparam logic [IO_IDX_W-1:0] IO_SYSTEM = 4'd4;

    // Byte lane numbering follows the data strobes
    localparam int LANE_LOWER = 0;
    localparam int LANE_UPPER = 1;

    //////////////////////////////////////////////////////////////////////
    // CPU data word

    // Seen either as one word or as two byte lanes.
    // lanes[1] is D15..D8 (UDS), lanes[0] is D7..D0 (LDS)
    typedef union packed {
        logic [DATA_W-1:0] word;
        logic [1:0][7:0]   lanes;
    } cpu_word_t;

endpackage

// ==== source/input_ports.sv ====
`timescale 1ns/1ps

module input_ports
    import f2_pkg::*;
(
    input  logic                clk,
    input  logic                cs,
    input  logic                io_swap,
    input  logic [IO_IDX_W-1:0] index,

    input  logic [7:0]          dswa,
    input  logic [7:0]          dswb,
    input  logic [9:0]          joystick_p1,
    input  logic [9:0]          joystick_p2,
    input  logic [1:0]          start,
    input  logic [1:0]          coin,

    output logic [7:0]          q
);

    logic [IO_IDX_W-1:0] idx;

    // Start, buttons 6..4, then directions in reversed order
    function automatic logic [7:0] player_byte(input logic st, input logic [9:0] joy);
        player_byte = {st, joy[6:4], joy[0], joy[1], joy[2], joy[3]};
    endfunction

    // Swapped boards see odd and even registers exchanged
    assign idx = {index[IO_IDX_W-1:1], index[0] ^ io_swap};

    //////////////////////////////////////////////////////////////////////
    // Read register, all inputs active low

    always_ff @(posedge clk) begin
        if (cs) begin
            case (idx)
                IO_DSWA:   q <= ~dswa;
                IO_DSWB:   q <= ~dswb;
                IO_P1:     q <= ~player_byte(start[0], joystick_p1);
                IO_P2:     q <= ~player_byte(start[1], joystick_p2);
                IO_SYSTEM: q <= ~{2'b00, start, coin, 2'b00};
                default:   q <= 8'hff;  // Unused
            endcase
        end
    end

endmodule

// ==== source/interrupt_ctrl.sv ====
`timescale 1ns/1ps

module interrupt_ctrl (
    input  logic       clk,
    input  logic       reset,
    input  logic       vblank_n,
    input  logic       dma_done,
    input  logic       iack,
    input  logic [2:0] ack_level,
    input  logic       cpu_lds_n,

    output logic [2:0] ipl_n
);

    localparam logic [2:0] LEVEL_VBL = 3'd5;
    localparam logic [2:0] LEVEL_DMA = 3'd6;

    logic vbl_prev;
    logic dma_prev;
    logic vbl_fall;
    logic dma_rise;
    logic req_vbl;
    logic req_dma;
    logic clr_vbl;
    logic clr_dma;

    // Acknowledge cycle carries the level on A3..A1
    assign clr_vbl = iack & ~cpu_lds_n & (ack_level == LEVEL_VBL);
    assign clr_dma = iack & ~cpu_lds_n & (ack_level == LEVEL_DMA);

    always_ff @(posedge clk) begin
        if (reset) begin
            vbl_prev <= 1'b1;
            dma_prev <= 1'b0;
            vbl_fall <= 1'b0;
            dma_rise <= 1'b0;
            req_vbl  <= 1'b0;
            req_dma  <= 1'b0;
        end else begin
            vbl_prev <= vblank_n;
            dma_prev <= dma_done;
            vbl_fall <= vbl_prev & ~vblank_n;
            dma_rise <= ~dma_prev & dma_done;

            if (clr_vbl) req_vbl <= 1'b0;
            if (vbl_fall) req_vbl <= 1'b1;   // New edge beats the clear
            if (clr_dma) req_dma <= 1'b0;
            if (dma_rise) req_dma <= 1'b1;
        end
    end

    // Priority encoder, DMA over vblank
    always_comb begin
        if (req_dma) begin
            ipl_n = ~LEVEL_DMA;
        end else if (req_vbl) begin
            ipl_n = ~LEVEL_VBL;
        end else begin
            ipl_n = 3'b111;
        end
    end

endmodule

// ==== source/work_ram.sv ====
`timescale 1ns/1ps

module work_ram
    import f2_pkg::*;
#(
    parameter int WORK_RAM_AW = 15
) (
    input  logic                   clk,
    input  logic                   cs,
    input  logic                   cpu_rw,
    input  logic [1:0]             cpu_ds_n,
    input  logic [WORK_RAM_AW-1:0] addr,
    input  cpu_word_t              din,

    output cpu_word_t              q
);

    localparam int DEPTH = 2 ** WORK_RAM_AW;

    cpu_word_t              mem [DEPTH];
    logic [WORK_RAM_AW-1:0] addr_q;

    // Each lane written on its own strobe
    always_ff @(posedge clk) begin
        if (cs && !cpu_rw) begin
            if (!cpu_ds_n[LANE_UPPER]) begin
                mem[addr].lanes[LANE_UPPER] <= din.lanes[LANE_UPPER];
            end
            if (!cpu_ds_n[LANE_LOWER]) begin
                mem[addr].lanes[LANE_LOWER] <= din.lanes[LANE_LOWER];
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= addr;
    end

    assign q = mem[addr_q];   // One cycle read latency

endmodule

// ==== tb.f ====
+incdir+testbench
source/f2_pkg.sv
source/board_config.sv
source/address_decoder.sv
source/work_ram.sv
source/input_ports.sv
source/interrupt_ctrl.sv
source/f2_cpu_bus.sv
testbench/tb_f2_cpu_bus.sv

// ==== testbench/tb_bus_tasks.svh ====
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// Failure handling and checks

task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1);
endtask

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    if (got !== expected) begin
        $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, expected);
        abort_run();
    end
endtask

// Inputs change a little after the rising edge
task automatic next_edge();
    @(posedge clk);
    #2;
endtask

//////////////////////////////////////////////////////////////////////
// Bus cycles

task automatic bus_cycle(input logic rw, input logic [1:0] ds_n, input logic [2:0] fc,
                         input logic [CPU_AW-1:0] addr, input logic [15:0] wdata,
                         output logic [15:0] rdata);
    int   waited;
    logic autovector;
    autovector = (fc == 3'd7);
    cpu_rw     = rw;
    cpu_ds_n   = ds_n;
    cpu_fc     = fc;
    cpu_addr   = addr;
    cpu_dout   = wdata;
    cpu_as_n   = 1'b0;
    next_edge();   // Strobe sampled here
    check_value("cpu_dtack_n,cpu_vpa_n early", {cpu_dtack_n, cpu_vpa_n}, 2'b11);
    waited = 0;
    while (cpu_dtack_n && cpu_vpa_n) begin
        if (waited == 8) begin
            $display("no acknowledge for the bus cycle at word address %h", addr);
            abort_run();
        end
        next_edge();
        waited++;
    end
    check_value("acknowledge latency", waited, 1);
    check_value("cpu_dtack_n,cpu_vpa_n", {cpu_dtack_n, cpu_vpa_n},
                autovector ? 2'b10 : 2'b01);
    rdata    = cpu_din;
    cpu_as_n = 1'b1;
    cpu_ds_n = 2'b11;
    cpu_rw   = 1'b1;
    next_edge();
    check_value("cpu_dtack_n,cpu_vpa_n released", {cpu_dtack_n, cpu_vpa_n}, 2'b11);
endtask

task automatic write_word(input logic [CPU_AW-1:0] addr, input logic [1:0] ds_n,
                          input logic [15:0] data);
    logic [15:0] ignored;
    bus_cycle(1'b0, ds_n, 3'd5, addr, data, ignored);
endtask

task automatic read_check(input logic [CPU_AW-1:0] addr, input logic [15:0] expected);
    logic [15:0] data;
    bus_cycle(1'b1, 2'b00, 3'd5, addr, 16'h0000, data);
    check_value("cpu_din", data, expected);
endtask

// Level travels on the low address bits, lower strobe only
task automatic acknowledge_irq(input logic [2:0] level);
    logic [15:0] ignored;
    bus_cycle(1'b1, 2'b10, 3'd7, {20'hfffff, level}, 16'h0000, ignored);
endtask

//////////////////////////////////////////////////////////////////////
// Reference model

task automatic map_for_game(input logic [GAME_W-1:0] g, output logic [7:0] work,
                            output logic [7:0] io, output logic swap);
    work = 8'h10;
    io   = 8'h30;
    swap = 1'b0;
    if (g == GAME_DINOREX) begin
        work = 8'h60;
        io   = 8'h40;
    end else if (g == GAME_QJINSEI) begin
        work = 8'h30;
        io   = 8'hb0;
        swap = 1'b1;
    end
endtask

function automatic logic [7:0] expected_io_byte(input logic [3:0] idx, input logic swap);
    logic [3:0] reg_idx;
    logic [7:0] raw;
    reg_idx = swap ? (idx ^ 4'd1) : idx;
    case (reg_idx)
        IO_DSWA:   raw = dswa;
        IO_DSWB:   raw = dswb;
        IO_P1:     raw = {start[0], joystick_p1[6:4], joystick_p1[0], joystick_p1[1],
                          joystick_p1[2], joystick_p1[3]};
        IO_P2:     raw = {start[1], joystick_p2[6:4], joystick_p2[0], joystick_p2[1],
                          joystick_p2[2], joystick_p2[3]};
        IO_SYSTEM: raw = {2'b00, start, coin, 2'b00};
        default:   raw = 8'h00;   // Reads as ff
    endcase
    return ~raw;
endfunction

// Idle level 0 shows as all ones
function automatic logic [2:0] expected_ipl(input logic [2:0] level);
    return ~level;
endfunction

//////////////////////////////////////////////////////////////////////
// Tests

task automatic apply_reset(input logic [GAME_W-1:0] g);
    game  = g;
    reset = 1'b1;
    next_edge();
    next_edge();
    reset = 1'b0;
    next_edge();   // Map registered out of reset
    map_for_game(g, map_work, map_io, map_swap);
endtask

task automatic test_ram_words();
    logic [CPU_AW-1:0] addr [16];
    logic [15:0]       data [16];
    logic [31:0]       rnd;
    int                i;
    for (i = 0; i < 16; i++) begin
        rnd     = $urandom;
        addr[i] = {map_work, rnd[14:4], i[3:0]};   // Distinct words
        data[i] = rnd[31:16];
        write_word(addr[i], 2'b00, data[i]);
    end
    for (i = 0; i < 16; i++) begin
        read_check(addr[i], data[i]);
    end
endtask

task automatic test_byte_lanes();
    logic [CPU_AW-1:0] addr;
    logic [31:0]       rnd;
    logic [15:0]       expected;
    rnd      = $urandom;
    addr     = {map_work, rnd[14:0]};
    expected = rnd[31:16];
    write_word(addr, 2'b00, expected);
    rnd = $urandom;
    write_word(addr, 2'b01, rnd[15:0]);   // Upper lane only
    expected[15:8] = rnd[15:8];
    read_check(addr, expected);
    rnd = $urandom;
    write_word(addr, 2'b10, rnd[15:0]);   // Lower lane only
    expected[7:0] = rnd[7:0];
    read_check(addr, expected);
endtask

task automatic test_io_reads();
    logic [31:0] rnd;
    logic [7:0]  b;
    logic [3:0]  idx;
    rnd         = $urandom;
    dswa        = rnd[7:0];
    dswb        = rnd[15:8];
    start       = rnd[17:16];
    coin        = rnd[19:18];
    rnd         = $urandom;
    joystick_p1 = rnd[9:0];
    joystick_p2 = rnd[25:16];
    for (idx = 0; idx < 8; idx++) begin
        b = expected_io_byte(idx, map_swap);
        read_check({map_io, 11'h000, idx}, {b, b});
    end
endtask

// Region f0 is in no game's map
task automatic test_unmapped();
    write_word({8'hf0, 15'h0123}, 2'b00, 16'hbeef);
    read_check({8'hf0, 15'h0123}, 16'h0000);
endtask

task automatic run_map_tests(input logic [GAME_W-1:0] g);
    apply_reset(g);
    test_ram_words();
    test_io_reads();
    test_unmapped();
endtask

task automatic test_vblank_irq();
    check_value("ipl_n", ipl_n, expected_ipl(3'd0));
    vblank_n = 1'b0;
    next_edge();
    next_edge();
    check_value("ipl_n", ipl_n, expected_ipl(3'd5));
    vblank_n = 1'b1;
    acknowledge_irq(3'd5);
    check_value("ipl_n", ipl_n, expected_ipl(3'd0));
endtask

task automatic test_both_irqs();
    vblank_n = 1'b0;
    dma_done = 1'b1;
    next_edge();
    next_edge();
    check_value("ipl_n", ipl_n, expected_ipl(3'd6));
    vblank_n = 1'b1;
    dma_done = 1'b0;
    acknowledge_irq(3'd6);
    check_value("ipl_n", ipl_n, expected_ipl(3'd5));
    acknowledge_irq(3'd5);
    check_value("ipl_n", ipl_n, expected_ipl(3'd0));
endtask

`endif

// ==== testbench/tb_f2_cpu_bus.sv ====
`timescale 1ns/1ps

module tb_f2_cpu_bus
    import f2_pkg::*;
();

    localparam int RAM_AW     = 15;
    localparam int MAX_CYCLES = 3000;

    logic              clk;
    logic              reset;
    logic [GAME_W-1:0] game;
    logic              cpu_as_n;
    logic [1:0]        cpu_ds_n;
    logic              cpu_rw;
    logic [2:0]        cpu_fc;
    logic [CPU_AW-1:0] cpu_addr;
    logic [DATA_W-1:0] cpu_dout;
    logic [DATA_W-1:0] cpu_din;
    logic              cpu_dtack_n;
    logic              cpu_vpa_n;
    logic [7:0]        dswa;
    logic [7:0]        dswb;
    logic [9:0]        joystick_p1;
    logic [9:0]        joystick_p2;
    logic [1:0]        start;
    logic [1:0]        coin;
    logic              vblank_n;
    logic              dma_done;
    logic [2:0]        ipl_n;

    // Map expected for the game under test
    logic [7:0]        map_work;
    logic [7:0]        map_io;
    logic              map_swap;
    int                cycle_count = 0;

    `include "tb_bus_tasks.svh"

    f2_cpu_bus #(.WORK_RAM_AW(RAM_AW)) DUT (
        .clk, .reset, .game,
        .cpu_as_n, .cpu_ds_n, .cpu_rw, .cpu_fc, .cpu_addr, .cpu_dout,
        .cpu_din, .cpu_dtack_n, .cpu_vpa_n,
        .dswa, .dswb, .joystick_p1, .joystick_p2, .start, .coin,
        .vblank_n, .dma_done, .ipl_n
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == MAX_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", MAX_CYCLES);
            abort_run();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        void'($urandom(32'hc9a));
        reset       = 1'b1;
        game        = GAME_FINALB;
        cpu_as_n    = 1'b1;
        cpu_ds_n    = 2'b11;
        cpu_rw      = 1'b1;
        cpu_fc      = 3'd0;
        cpu_addr    = '0;
        cpu_dout    = '0;
        dswa        = 8'h00;
        dswb        = 8'h00;
        joystick_p1 = 10'h000;
        joystick_p2 = 10'h000;
        start       = 2'b00;
        coin        = 2'b00;
        vblank_n    = 1'b1;   // Idle high
        dma_done    = 1'b0;

        run_map_tests(GAME_FINALB);
        run_map_tests(GAME_DINOREX);
        run_map_tests(GAME_QJINSEI);
        test_byte_lanes();
        test_vblank_irq();
        test_both_irqs();

        $display("TESTS PASSED");
        $finish;
    end

endmodule
